// ==== div_pipe.sv ====
`timescale 1ns/10ps

module div_pipe
  import mod_pkg::*;
(
  input  logic CLK,
  input  logic rst_n,
  input  quo_t dividend,
  input  div_t divisor,
  output quo_t quotient,
  output div_t remainder
);

  // Entry 0 is the input register, entry i+1 is the output of bit stage i
  div_t rem_q [1:DIV_STAGES];  // Partial remainder, the first stage starts from zero
  quo_t dvd_q [DIV_STAGES+1];  // Dividend bits still to go, quotient bits shift in below
  div_t dsr_q [DIV_STAGES+1];  // Divisor travels with its own dividend

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      dvd_q[0] <= '0;
      dsr_q[0] <= '0;
    end else begin
      dvd_q[0] <= dividend;
      dsr_q[0] <= divisor;
    end
  end

  for (genvar i = 0; i < DIV_STAGES; i++) begin : g_stage
    logic [$bits(div_t):0] trial;
    logic [$bits(div_t):0] diff;
    logic                  fits;

    // Bring down the next dividend bit and try the subtraction
    if (i == 0) begin : g_first
      assign trial = {div_t'(0), dvd_q[0][$bits(quo_t)-1]};
    end else begin : g_next
      assign trial = {rem_q[i], dvd_q[i][$bits(quo_t)-1]};
    end
    assign diff  = trial - {1'b0, dsr_q[i]};
    assign fits  = (trial >= {1'b0, dsr_q[i]});

    always_ff @(posedge CLK or negedge rst_n) begin
      if (!rst_n) begin
        rem_q[i+1] <= '0;
        dvd_q[i+1] <= '0;
        dsr_q[i+1] <= '0;
      end else begin
        // Restore by keeping the trial value when the divisor does not fit
        rem_q[i+1] <= fits ? diff[$bits(div_t)-1:0] : trial[$bits(div_t)-1:0];
        dvd_q[i+1] <= {dvd_q[i][$bits(quo_t)-2:0], fits};
        dsr_q[i+1] <= dsr_q[i];
      end
    end
  end

  // After the last stage the shift register holds the full quotient
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      quotient  <= '0;
      remainder <= '0;
    end else begin
      quotient  <= dvd_q[DIV_STAGES];
      remainder <= rem_q[DIV_STAGES];
    end
  end

endmodule

// ==== mod_pkg.sv ====
package mod_pkg;

  // Widths that carry a meaning across the modulation path
  typedef logic [63:0] time_t;    // System time counter
  typedef logic [31:0] div_t;     // Frequency divisor and divider remainder
  typedef logic [63:0] quo_t;     // Divider dividend and quotient
  typedef logic [14:0] idx_t;     // Sample index into one segment
  typedef logic [7:0]  sample_t;  // Modulation sample
  typedef logic        seg_t;     // Segment select

  // One quotient bit is resolved per pipeline stage
  localparam int DIV_STAGES = $bits(quo_t);

  // Bit stages plus the input and output registers
  localparam int DIV_LATENCY = DIV_STAGES + 2;

  // Both dividers of a timer chain back to back
  localparam int UPDATE_LATENCY = 2 * DIV_LATENCY;

  localparam int MOD_BUF_DEPTH = 32768;  // Samples per segment

  // Counter that spans the flush of a full timer chain
  typedef logic [$clog2(UPDATE_LATENCY)-1:0] flush_cnt_t;

  typedef enum logic {
    IDLE,
    FLUSH
  } ctrl_state_t;

endpackage

// ==== mod_timer_if.sv ====
`timescale 1ns/10ps

// Settings handed from the control block to the timer
// They change only when an update is accepted and are then held
interface mod_timer_if
  import mod_pkg::*;
();

  div_t freq_div_0;  // Divisor of segment 0
  div_t freq_div_1;  // Divisor of segment 1

  // Cycle lengths arrive with the extra one already added
  div_t cycle_0;
  div_t cycle_1;

  modport ctrl (
    output freq_div_0,
    output freq_div_1,
    output cycle_0,
    output cycle_1
  );

  modport timer (
    input freq_div_0,
    input freq_div_1,
    input cycle_0,
    input cycle_1
  );

endinterface

// ==== modulation_buffer.sv ====
`timescale 1ns/10ps

module modulation_buffer
  import mod_pkg::*;
(
  input  logic    CLK,
  input  logic    rst_n,
  input  logic    wr_en,
  input  seg_t    wr_segment,
  input  idx_t    wr_addr,
  input  sample_t wr_data,
  input  seg_t    seg_active,
  input  idx_t    idx_0,
  input  idx_t    idx_1,
  output idx_t    idx,
  output sample_t intensity
);

  // One block RAM per segment
  sample_t mem [2][MOD_BUF_DEPTH];

  // Only the active segment's index is read out
  assign idx = seg_active ? idx_1 : idx_0;

  // Host write port
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_segment][wr_addr] <= wr_data;
    end
  end

  // Registered read at the active position
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      intensity <= '0;
    end else begin
      intensity <= mem[seg_active][idx];
    end
  end

endmodule

// ==== modulation_ctrl.sv ====
`timescale 1ns/10ps

module modulation_ctrl
  import mod_pkg::*;
(
  input  logic       CLK,
  input  logic       rst_n,
  input  logic       update_req,
  input  seg_t       req_segment,
  input  div_t       freq_div_0,
  input  div_t       freq_div_1,
  input  idx_t       cycle_0,
  input  idx_t       cycle_1,
  output logic       busy,
  output logic       update_done,
  output seg_t       seg_active,
  mod_timer_if.ctrl  tmr
);

  ctrl_state_t state;
  flush_cnt_t  cnt;          // Cycles spent in FLUSH
  seg_t        seg_pending;  // Segment to switch to once the chain has flushed

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      state          <= IDLE;
      cnt            <= '0;
      seg_pending    <= '0;
      seg_active     <= '0;
      update_done    <= 1'b0;
      // Divide by one modulo one, so both indices sit at 0
      tmr.freq_div_0 <= div_t'(1);
      tmr.freq_div_1 <= div_t'(1);
      tmr.cycle_0    <= div_t'(1);
      tmr.cycle_1    <= div_t'(1);
    end else begin
      update_done <= 1'b0;  // Single cycle strobe
      case (state)
        IDLE: begin
          if (update_req) begin
            state          <= FLUSH;
            cnt            <= '0;
            seg_pending    <= req_segment;
            tmr.freq_div_0 <= freq_div_0;
            tmr.freq_div_1 <= freq_div_1;
            tmr.cycle_0    <= div_t'(cycle_0) + div_t'(1);
            tmr.cycle_1    <= div_t'(cycle_1) + div_t'(1);
          end
        end
        FLUSH: begin
          // Requests arriving here are dropped
          cnt <= cnt + flush_cnt_t'(1);
          if (cnt == flush_cnt_t'(UPDATE_LATENCY - 1)) begin
            state       <= IDLE;
            update_done <= 1'b1;
            seg_active  <= seg_pending;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

  assign busy = (state == FLUSH);

endmodule

// ==== modulation_props.sv ====
`timescale 1ns/10ps

module modulation_props
  import mod_pkg::*;
(
  input logic    CLK,
  input logic    rst_n,
  input time_t   sys_time,
  input logic    update_req,
  input seg_t    req_segment,
  input div_t    freq_div_0,
  input div_t    freq_div_1,
  input idx_t    cycle_0,
  input idx_t    cycle_1,
  input logic    busy,
  input logic    update_done,
  input seg_t    seg_active,
  input idx_t    idx
);

  int    fail_count = 0;
  int    age;        // Cycles since the last accepted request, saturating
  int    since_rst;  // Cycles since reset was released, saturating
  time_t hist [UPDATE_LATENCY];
  div_t  rec_div [2];
  idx_t  rec_cyc [2];
  seg_t  rec_seg;
  logic  accepted;
  idx_t  exp_idx;

  function automatic idx_t index_at(time_t t, div_t d, idx_t c);
    time_t periods;
    periods = t / time_t'(d);
    return idx_t'(periods % (time_t'(c) + time_t'(1)));
  endfunction

  assign accepted = update_req && (age >= UPDATE_LATENCY);  // Model of busy being low
  assign exp_idx  = index_at(hist[UPDATE_LATENCY-1], rec_div[rec_seg], rec_cyc[rec_seg]);

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      age        <= UPDATE_LATENCY + 1;
      since_rst  <= 0;
      rec_seg    <= '0;
      rec_div[0] <= div_t'(1);
      rec_div[1] <= div_t'(1);
      rec_cyc[0] <= '0;
      rec_cyc[1] <= '0;
      for (int i = 0; i < UPDATE_LATENCY; i++) begin
        hist[i] <= '0;
      end
    end else begin
      if (since_rst < UPDATE_LATENCY) since_rst <= since_rst + 1;
      if (accepted) begin
        age        <= 0;
        rec_seg    <= req_segment;
        rec_div[0] <= freq_div_0;
        rec_div[1] <= freq_div_1;
        rec_cyc[0] <= cycle_0;
        rec_cyc[1] <= cycle_1;
      end else if (age <= UPDATE_LATENCY) begin
        age <= age + 1;
      end
      hist[0] <= sys_time;  // hist[i] holds the time seen i+1 cycles ago
      for (int i = 1; i < UPDATE_LATENCY; i++) begin
        hist[i] <= hist[i-1];
      end
    end
  end

  a_reset_state: assert property (@(posedge CLK)
    (!rst_n || $rose(rst_n)) |-> (!busy && !update_done && seg_active == 1'b0))
    else begin
      $error("Outputs not at reset values");
      fail_count++;
    end

  a_reset_idx: assert property (@(posedge CLK)
    (rst_n && since_rst < UPDATE_LATENCY) |-> (idx == '0))
    else begin
      $error("Index not zero after reset");
      fail_count++;
    end

  a_busy_window: assert property (@(posedge CLK) disable iff (!rst_n)
    (age < UPDATE_LATENCY) |-> busy)
    else begin
      $error("Busy dropped during flush");
      fail_count++;
    end

  // Also catches a request taken while busy
  a_busy_only_in_window: assert property (@(posedge CLK) disable iff (!rst_n)
    busy |-> (age < UPDATE_LATENCY))
    else begin
      $error("Busy high outside a flush");
      fail_count++;
    end

  a_done_on_time: assert property (@(posedge CLK) disable iff (!rst_n)
    (age == UPDATE_LATENCY) |-> (update_done && !busy && seg_active == rec_seg))
    else begin
      $error("Update done missing or wrong segment");
      fail_count++;
    end

  a_done_only_on_time: assert property (@(posedge CLK) disable iff (!rst_n)
    update_done |-> (age == UPDATE_LATENCY))
    else begin
      $error("Update done at the wrong time");
      fail_count++;
    end

  a_seg_stable: assert property (@(posedge CLK) disable iff (!rst_n)
    !update_done |-> $stable(seg_active))
    else begin
      $error("Segment changed without update done");
      fail_count++;
    end

  a_index: assert property (@(posedge CLK) disable iff (!rst_n)
    (age >= UPDATE_LATENCY) |-> (idx == exp_idx))
    else begin
      $error("Index does not follow the time formula");
      fail_count++;
    end

endmodule

bind modulation_top modulation_props u_props (
  .CLK         (CLK),
  .rst_n       (rst_n),
  .sys_time    (sys_time),
  .update_req  (update_req),
  .req_segment (req_segment),
  .freq_div_0  (freq_div_0),
  .freq_div_1  (freq_div_1),
  .cycle_0     (cycle_0),
  .cycle_1     (cycle_1),
  .busy        (busy),
  .update_done (update_done),
  .seg_active  (seg_active),
  .idx         (idx)
);

// ==== modulation_timer.sv ====
`timescale 1ns/10ps

// Turns system time into a sample index for each segment
// idx = (sys_time / freq_div) mod (cycle + 1), ready UPDATE_LATENCY cycles later
module modulation_timer
  import mod_pkg::*;
(
  input  logic              CLK,
  input  logic              rst_n,
  input  time_t             sys_time,
  mod_timer_if.timer        tmr,
  output idx_t              idx_0,
  output idx_t              idx_1
);

  quo_t quo_0;  // Time in units of the segment 0 sample period
  quo_t quo_1;
  div_t rem_0;  // Position inside the segment 0 cycle
  div_t rem_1;

  // Segment 0 chain

  div_pipe u_div_freq_0 (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dividend  (sys_time),
    .divisor   (tmr.freq_div_0),
    .quotient  (quo_0),
    .remainder ()
  );

  div_pipe u_div_cycle_0 (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dividend  (quo_0),
    .divisor   (tmr.cycle_0),  // Already holds cycle + 1
    .quotient  (),
    .remainder (rem_0)
  );

  // Segment 1 chain

  div_pipe u_div_freq_1 (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dividend  (sys_time),
    .divisor   (tmr.freq_div_1),
    .quotient  (quo_1),
    .remainder ()
  );

  div_pipe u_div_cycle_1 (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .dividend  (quo_1),
    .divisor   (tmr.cycle_1),
    .quotient  (),
    .remainder (rem_1)
  );

  // The remainder is below the cycle length, which never exceeds the segment depth
  assign idx_0 = rem_0[$bits(idx_t)-1:0];
  assign idx_1 = rem_1[$bits(idx_t)-1:0];

endmodule

// ==== modulation_top.sv ====
`timescale 1ns/10ps

module modulation_top
  import mod_pkg::*;
(
  input  logic    CLK,
  input  logic    rst_n,
  input  time_t   sys_time,
  input  logic    update_req,
  input  seg_t    req_segment,
  input  div_t    freq_div_0,
  input  div_t    freq_div_1,
  input  idx_t    cycle_0,
  input  idx_t    cycle_1,
  input  logic    wr_en,
  input  seg_t    wr_segment,
  input  idx_t    wr_addr,
  input  sample_t wr_data,
  output logic    busy,
  output logic    update_done,
  output seg_t    seg_active,
  output idx_t    idx,
  output sample_t intensity
);

  mod_timer_if tmr_if ();

  idx_t idx_0;
  idx_t idx_1;

  modulation_ctrl u_ctrl (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .update_req  (update_req),
    .req_segment (req_segment),
    .freq_div_0  (freq_div_0),
    .freq_div_1  (freq_div_1),
    .cycle_0     (cycle_0),
    .cycle_1     (cycle_1),
    .busy        (busy),
    .update_done (update_done),
    .seg_active  (seg_active),
    .tmr         (tmr_if.ctrl)
  );

  modulation_timer u_timer (
    .CLK      (CLK),
    .rst_n    (rst_n),
    .sys_time (sys_time),
    .tmr      (tmr_if.timer),
    .idx_0    (idx_0),
    .idx_1    (idx_1)
  );

  modulation_buffer u_buffer (
    .CLK        (CLK),
    .rst_n      (rst_n),
    .wr_en      (wr_en),
    .wr_segment (wr_segment),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .seg_active (seg_active),
    .idx_0      (idx_0),
    .idx_1      (idx_1),
    .idx        (idx),
    .intensity  (intensity)
  );

endmodule

// ==== sources.f ====
mod_pkg.sv
mod_timer_if.sv
div_pipe.sv
modulation_timer.sv
modulation_ctrl.sv
modulation_buffer.sv
modulation_top.sv
modulation_props.sv
tb_modulation.sv

// ==== tb_modulation.sv ====
`timescale 1ns/10ps

module tb_modulation
  import mod_pkg::*;
();

  localparam int SEED          = 85528;
  localparam int FILL_WORDS    = 256;
  localparam int NUM_UPDATES   = 8;
  localparam int SETTLE_CYCLES = 300;
  // 512 write cycles and 8 updates of about 440 cycles, with margin on top
  localparam int MAX_CYCLES    = 6000;

  logic    CLK;
  logic    rst_n;
  time_t   sys_time;
  logic    update_req;
  seg_t    req_segment;
  div_t    freq_div_0;
  div_t    freq_div_1;
  idx_t    cycle_0;
  idx_t    cycle_1;
  logic    wr_en;
  seg_t    wr_segment;
  idx_t    wr_addr;
  sample_t wr_data;
  logic    busy;
  logic    update_done;
  seg_t    seg_active;
  idx_t    idx;
  sample_t intensity;

  sample_t shadow [2][MOD_BUF_DEPTH];  // What the host has written so far
  bit      known [2][MOD_BUF_DEPTH];
  sample_t exp_intensity;
  idx_t    exp_at;
  bit      exp_valid = 1'b0;
  int      mismatches = 0;
  int      checks = 0;
  int      cycle_count = 0;
  int      errors;

  modulation_top DUT (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .sys_time    (sys_time),
    .update_req  (update_req),
    .req_segment (req_segment),
    .freq_div_0  (freq_div_0),
    .freq_div_1  (freq_div_1),
    .cycle_0     (cycle_0),
    .cycle_1     (cycle_1),
    .wr_en       (wr_en),
    .wr_segment  (wr_segment),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .busy        (busy),
    .update_done (update_done),
    .seg_active  (seg_active),
    .idx         (idx),
    .intensity   (intensity)
  );

  initial begin
    CLK = 1'b0;
    forever #2 CLK = ~CLK;
  end

  // System time advances by 1 to 3 per cycle
  always @(posedge CLK) begin
    if (!rst_n) begin
      sys_time <= '0;
    end else begin
      sys_time <= sys_time + time_t'($urandom_range(3, 1));
    end
  end

  // Readout is one cycle behind the index, writes land before the next read
  always @(posedge CLK) begin
    if (exp_valid && rst_n) begin
      checks++;
      if (intensity !== exp_intensity) begin
        mismatches++;
        $display("FAILED at %0t: intensity %0h, expected %0h at index %0d",
                 $time, intensity, exp_intensity, exp_at);
      end
    end
    if (rst_n) begin
      exp_valid     = known[seg_active][idx];
      exp_intensity = shadow[seg_active][idx];
      exp_at        = idx;
      if (wr_en) begin
        shadow[wr_segment][wr_addr] = wr_data;
        known[wr_segment][wr_addr]  = 1'b1;
      end
    end else begin
      exp_valid = 1'b0;
    end
  end

  always @(posedge CLK) begin
    cycle_count++;
    if (cycle_count >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display(">>> FAIL");
      $finish;
    end
  end

  task automatic fill_segments();
    for (int s = 0; s < 2; s++) begin
      for (int a = 0; a < FILL_WORDS; a++) begin
        @(posedge CLK);
        wr_en      <= 1'b1;
        wr_segment <= seg_t'(s);
        wr_addr    <= idx_t'(a);
        wr_data    <= sample_t'($urandom_range(255, 0));
      end
    end
    @(posedge CLK);
    wr_en <= 1'b0;
  endtask

  task automatic drive_random_settings();
    freq_div_0 <= div_t'($urandom_range(16, 1));
    freq_div_1 <= div_t'($urandom_range(16, 1));
    cycle_0    <= idx_t'($urandom_range(254, 0));
    cycle_1    <= idx_t'($urandom_range(254, 0));
  endtask

  task automatic request_update(input seg_t seg, input bit retry_while_busy);
    @(posedge CLK);
    update_req  <= 1'b1;
    req_segment <= seg;
    drive_random_settings();
    @(posedge CLK);
    update_req <= 1'b0;
    drive_random_settings();  // Later values must not reach the latched settings
    if (retry_while_busy) begin
      repeat (20) @(posedge CLK);
      update_req  <= 1'b1;
      req_segment <= ~seg;
      drive_random_settings();
      @(posedge CLK);
      update_req <= 1'b0;
    end
  endtask

  task automatic wait_update_done();
    @(posedge CLK);
    while (update_done !== 1'b1) begin
      @(posedge CLK);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst_n       = 1'b1;
    sys_time    = '0;
    update_req  = 1'b0;
    req_segment = '0;
    freq_div_0  = div_t'(1);
    freq_div_1  = div_t'(1);
    cycle_0     = '0;
    cycle_1     = '0;
    wr_en       = 1'b0;
    wr_segment  = '0;
    wr_addr     = '0;
    wr_data     = '0;
    #1 rst_n = 1'b0;  // Clean falling edge ahead of the first clock
    repeat (16) @(posedge CLK);
    rst_n <= 1'b1;

    fill_segments();

    for (int u = 0; u < NUM_UPDATES; u++) begin
      request_update(seg_t'(u % 2 == 0), u % 2 == 1);
      wait_update_done();
      repeat (SETTLE_CYCLES) @(posedge CLK);
    end

    errors = mismatches + DUT.u_props.fail_count;
    if (checks == 0) begin
      $display("No intensity sample was ever checked");
      errors++;
    end
    $display("Errors: %0d (%0d intensity mismatches, %0d assertion failures, %0d checks)",
             errors, mismatches, DUT.u_props.fail_count, checks);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule
